/* axi_mem.f */
hdl/axi_mem_pkg.sv
hdl/axi_burst_addr.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/axi_byte_mem.sv
hdl/axi_mem_slave.sv
verification/axi_mem_checker.sv
verification/axi_mem_tb.sv

/* hdl/axi_burst_addr.sv */
`timescale 1ns/1ps

module axi_burst_addr (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           load,
  input  axi_mem_pkg::addr_req_t         req,
  input  logic                           advance,
  output logic [axi_mem_pkg::MEM_AW-1:0] beat_addr
);
  import axi_mem_pkg::*;

  burst_e            burst_q;
  logic [MEM_AW-1:0] start_addr;
  logic [MEM_AW-1:0] cur_addr;
  logic [MEM_AW-1:0] step;       // bytes per beat
  logic [MEM_AW-1:0] wrap_base;
  logic [MEM_AW-1:0] wrap_mask;  // wrap block size minus one
  logic [MEM_AW:0]   ld_span;
  logic [MEM_AW-1:0] ld_mask;
  logic [MEM_AW-1:0] nxt_addr;

  // block covered by all (len+1) beats of the burst
  assign ld_span = ((MEM_AW+1)'(req.len) + 1'b1) << req.size;
  assign ld_mask = MEM_AW'(ld_span - 1'b1);

  always_comb begin
    case (burst_q)
      BURST_FIXED: nxt_addr = start_addr;
      BURST_WRAP:  nxt_addr = wrap_base | ((cur_addr + step) & wrap_mask);
      default:     nxt_addr = cur_addr + step;  // incr wraps at 128 through the 7-bit add
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      burst_q    <= BURST_INCR;
      start_addr <= '0;
      cur_addr   <= '0;
      step       <= '0;
      wrap_base  <= '0;
      wrap_mask  <= '0;
    end else if (load) begin
      burst_q    <= req.burst;
      start_addr <= req.addr[MEM_AW-1:0];
      cur_addr   <= req.addr[MEM_AW-1:0];
      step       <= MEM_AW'(1) << req.size;
      wrap_base  <= req.addr[MEM_AW-1:0] & ~ld_mask;
      wrap_mask  <= ld_mask;
    end else if (advance) begin
      cur_addr <= nxt_addr;
    end
  end

  assign beat_addr = cur_addr;

endmodule

/* hdl/axi_byte_mem.sv */
`timescale 1ns/1ps

module axi_byte_mem (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           wr_en,
  input  logic [axi_mem_pkg::MEM_AW-1:0] wr_addr,
  input  logic [axi_mem_pkg::STRB_W-1:0] wr_lanes,
  input  logic [axi_mem_pkg::DATA_W-1:0] wr_data,
  input  logic [axi_mem_pkg::MEM_AW-1:0] rd_addr,
  input  logic [axi_mem_pkg::STRB_W-1:0] rd_lanes,
  output logic [axi_mem_pkg::DATA_W-1:0] rd_data
);
  import axi_mem_pkg::*;

  logic [7:0] mem [MEM_BYTES] = '{default: MEM_INIT};

  // lane i sits at addr + i, 7-bit index rolls over at 128
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_lanes[i])
          mem[wr_addr + MEM_AW'(i)] <= wr_data[8*i +: 8];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      rd_data[8*i +: 8] = rd_lanes[i] ? mem[rd_addr + MEM_AW'(i)] : 8'h00;
    end
  end

  a_wr_en_known: assert property (@(posedge clk) disable iff (!resetn)
    !$isunknown(wr_en))
    else $error("wr_en unknown");

endmodule

/* hdl/axi_mem_pkg.sv */
package axi_mem_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int ID_W      = 4;
  localparam int LEN_W     = 4;   // beats minus one
  localparam int MEM_BYTES = 128;
  localparam int MEM_AW    = 7;
  localparam int MAX_SIZE  = 2;   // four bytes per beat
  localparam logic [7:0] MEM_INIT = 8'h0c;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  //////////////////////////////////////////////////////////////////////
  // channel payloads

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;  // log2 of bytes per beat
    burst_e            burst;
  } addr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    resp_e           resp;
  } b_resp_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } r_beat_t;

  // rules are checked in priority order
  function automatic resp_e req_resp(addr_req_t req);
    resp_e resp;
    if (req.size > MAX_SIZE)
      resp = RESP_SLVERR;
    else if (req.burst == BURST_WRAP && !(req.len inside {4'd1, 4'd3, 4'd7, 4'd15}))
      resp = RESP_SLVERR;
    else if (req.addr >= MEM_BYTES)
      resp = RESP_DECERR;
    else
      resp = RESP_OKAY;
    return resp;
  endfunction

  // lanes below the bytes per beat of a size code
  function automatic logic [STRB_W-1:0] lane_mask(logic [2:0] size);
    logic [STRB_W-1:0] mask;
    for (int i = 0; i < STRB_W; i++) begin
      mask[i] = (i < (1 << size));
    end
    return mask;
  endfunction

endpackage

/* hdl/axi_mem_slave.sv */
`timescale 1ns/1ps

module axi_mem_slave (
  input  logic                    clk,
  input  logic                    resetn,
  // write address
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_mem_pkg::addr_req_t  aw,
  // write data
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_mem_pkg::w_beat_t    w,
  // write response
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_mem_pkg::b_resp_t    b,
  // read address
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_mem_pkg::addr_req_t  ar,
  // read data
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_mem_pkg::r_beat_t    r
);
  import axi_mem_pkg::*;

  logic              wr_load, wr_advance;
  logic [MEM_AW-1:0] wr_beat_addr;
  logic              rd_load, rd_advance;
  logic [MEM_AW-1:0] rd_beat_addr;

  logic              wr_en;
  logic [MEM_AW-1:0] wr_addr;
  logic [STRB_W-1:0] wr_lanes;
  logic [DATA_W-1:0] wr_data;
  logic [MEM_AW-1:0] rd_addr;
  logic [STRB_W-1:0] rd_lanes;
  logic [DATA_W-1:0] rd_data;

  //////////////////////////////////////////////////////////////////////
  // write path

  axi_write_ctrl u_write_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw           (aw),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w            (w),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .b            (b),
    .addr_load    (wr_load),
    .addr_advance (wr_advance),
    .beat_addr    (wr_beat_addr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_lanes     (wr_lanes),
    .wr_data      (wr_data)
  );

  axi_burst_addr wr_addr_gen (
    .clk       (clk),
    .resetn    (resetn),
    .load      (wr_load),
    .req       (aw),
    .advance   (wr_advance),
    .beat_addr (wr_beat_addr)
  );

  //////////////////////////////////////////////////////////////////////
  // read path

  axi_read_ctrl u_read_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r            (r),
    .addr_load    (rd_load),
    .addr_advance (rd_advance),
    .beat_addr    (rd_beat_addr),
    .rd_addr      (rd_addr),
    .rd_lanes     (rd_lanes),
    .rd_data      (rd_data)
  );

  axi_burst_addr rd_addr_gen (
    .clk       (clk),
    .resetn    (resetn),
    .load      (rd_load),
    .req       (ar),
    .advance   (rd_advance),
    .beat_addr (rd_beat_addr)
  );

  axi_byte_mem u_mem (
    .clk      (clk),
    .resetn   (resetn),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_lanes (wr_lanes),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_lanes (rd_lanes),
    .rd_data  (rd_data)
  );

endmodule

/* hdl/axi_read_ctrl.sv */
`timescale 1ns/1ps

module axi_read_ctrl (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           ar_valid,
  output logic                           ar_ready,
  input  axi_mem_pkg::addr_req_t         ar,
  output logic                           r_valid,
  input  logic                           r_ready,
  output axi_mem_pkg::r_beat_t           r,
  output logic                           addr_load,
  output logic                           addr_advance,
  input  logic [axi_mem_pkg::MEM_AW-1:0] beat_addr,
  output logic [axi_mem_pkg::MEM_AW-1:0] rd_addr,
  output logic [axi_mem_pkg::STRB_W-1:0] rd_lanes,
  input  logic [axi_mem_pkg::DATA_W-1:0] rd_data
);
  import axi_mem_pkg::*;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  rd_state_e        state;
  logic [LEN_W-1:0] beat_cnt;
  logic [ID_W-1:0]  id_q;
  resp_e            resp_q;
  logic [LEN_W-1:0] len_q;
  logic [2:0]       size_q;
  logic             ar_fire, r_fire;
  logic             last_beat;

  assign ar_fire   = ar_valid && ar_ready;
  assign r_fire    = r_valid && r_ready;
  assign last_beat = (beat_cnt == len_q);

  //////////////////////////////////////////////////////////////////////
  // channel FSM

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= RD_IDLE;
      ar_ready <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          ar_ready <= 1'b1;
          if (ar_fire) begin
            state    <= RD_DATA;
            ar_ready <= 1'b0;
            beat_cnt <= '0;
          end
        end
        RD_DATA: begin
          if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state    <= RD_IDLE;
              ar_ready <= 1'b1;  // next request accepted a cycle later
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= ar.id;
      resp_q <= req_resp(ar);
      len_q  <= ar.len;
      size_q <= ar.size;
    end
  end

  assign addr_load    = ar_fire;
  assign addr_advance = r_fire;

  // upper lanes masked to zero, an errored burst reads no lane at all
  assign rd_addr  = beat_addr;
  assign rd_lanes = (resp_q == RESP_OKAY) ? lane_mask(size_q) : '0;

  assign r_valid = (state == RD_DATA);
  assign r       = '{id: id_q, data: rd_data, resp: resp_q, last: last_beat};

  a_r_stable: assert property (@(posedge clk) disable iff (!resetn)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)))
    else $error("read beat changed while stalled");

endmodule

/* hdl/axi_write_ctrl.sv */
`timescale 1ns/1ps

module axi_write_ctrl (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           aw_valid,
  output logic                           aw_ready,
  input  axi_mem_pkg::addr_req_t         aw,
  input  logic                           w_valid,
  output logic                           w_ready,
  input  axi_mem_pkg::w_beat_t           w,
  output logic                           b_valid,
  input  logic                           b_ready,
  output axi_mem_pkg::b_resp_t           b,
  output logic                           addr_load,
  output logic                           addr_advance,
  input  logic [axi_mem_pkg::MEM_AW-1:0] beat_addr,
  output logic                           wr_en,
  output logic [axi_mem_pkg::MEM_AW-1:0] wr_addr,
  output logic [axi_mem_pkg::STRB_W-1:0] wr_lanes,
  output logic [axi_mem_pkg::DATA_W-1:0] wr_data
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e         state;
  logic [LEN_W-1:0]  beat_cnt;
  logic [ID_W-1:0]   id_q;
  resp_e             resp_q;
  logic [LEN_W-1:0]  len_q;
  logic [2:0]        size_q;
  logic              aw_fire, w_fire, b_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign b_fire  = b_valid && b_ready;

  //////////////////////////////////////////////////////////////////////
  // channel FSM

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= WR_IDLE;
      aw_ready <= 1'b0;  // rises on the first edge out of reset
      beat_cnt <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          aw_ready <= 1'b1;
          if (aw_fire) begin
            state    <= WR_DATA;
            aw_ready <= 1'b0;
            beat_cnt <= '0;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w.last)
              state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state    <= WR_IDLE;
            aw_ready <= 1'b1;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // request fields held for the whole burst
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= aw.id;
      resp_q <= req_resp(aw);
      len_q  <= aw.len;
      size_q <= aw.size;
    end
  end

  assign w_ready = (state == WR_DATA);
  assign b_valid = (state == WR_RESP);
  assign b       = '{id: id_q, resp: resp_q};

  assign addr_load    = aw_fire;
  assign addr_advance = w_fire;

  // lane i lands on beat_addr + i, only lanes inside the beat size
  assign wr_en    = w_fire && (resp_q == RESP_OKAY);
  assign wr_addr  = beat_addr;
  assign wr_lanes = w.strb & lane_mask(size_q);
  assign wr_data  = w.data;

  a_wlast_count: assert property (@(posedge clk) disable iff (!resetn)
    w_fire |-> (w.last == (beat_cnt == len_q)))
    else $error("wlast does not match burst length");

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f axi_mem.f \
  --top-module axi_mem_tb -o axi_mem_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/axi_mem_sim)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/axi_mem_checker.sv */
`timescale 1ns/1ps

module axi_mem_checker (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   aw_valid, aw_ready,
  input  axi_mem_pkg::addr_req_t aw,
  input  logic                   w_valid, w_ready,
  input  axi_mem_pkg::w_beat_t   w,
  input  logic                   b_valid, b_ready,
  input  axi_mem_pkg::b_resp_t   b,
  input  logic                   ar_valid, ar_ready,
  input  axi_mem_pkg::addr_req_t ar,
  input  logic                   r_valid, r_ready,
  input  axi_mem_pkg::r_beat_t   r,
  output int                     errors,
  output int                     writes_done,
  output int                     reads_done
);
  import axi_mem_pkg::*;

  logic [7:0] model [MEM_BYTES];   // reference copy of the slave memory
  addr_req_t  wr_req, rd_req;
  resp_e      wr_resp, rd_resp;
  int         wr_beat, rd_beat;
  int         wr_mark, rd_mark;    // error count when the burst opened
  logic       wr_open, rd_open;

  initial begin
    for (int i = 0; i < MEM_BYTES; i++)
      model[i] = MEM_INIT;
    errors      = 0;
    writes_done = 0;
    reads_done  = 0;
    wr_open     = 1'b0;
    rd_open     = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // reference rules

  function automatic resp_e expected_resp(addr_req_t req);
    logic  wrap_len_ok;
    resp_e resp;
    wrap_len_ok = (req.len == 4'd1) || (req.len == 4'd3) || (req.len == 4'd7) || (req.len == 4'd15);
    resp = RESP_OKAY;
    if (req.size > MAX_SIZE)
      resp = RESP_SLVERR;
    else if (req.burst == BURST_WRAP && !wrap_len_ok)
      resp = RESP_SLVERR;
    else if (req.addr >= MEM_BYTES)
      resp = RESP_DECERR;
    return resp;
  endfunction

  // address of beat k, modulo the memory size
  function automatic logic [MEM_AW-1:0] beat_addr_of(addr_req_t req, int k);
    int bpb, blk, start, base;
    logic [MEM_AW-1:0] addr;
    bpb   = 1 << req.size;
    start = int'(req.addr[MEM_AW-1:0]);
    blk   = (req.len + 1) * bpb;       // wrap block, aligned to its own size
    base  = start - (start % blk);
    case (req.burst)
      BURST_FIXED: addr = MEM_AW'(start);
      BURST_WRAP:  addr = MEM_AW'(base + (start - base + k * bpb) % blk);
      default:     addr = MEM_AW'(start + k * bpb);
    endcase
    return addr;
  endfunction

  function automatic void write_model(addr_req_t req, int k, w_beat_t beat);
    logic [MEM_AW-1:0] a;
    a = beat_addr_of(req, k);
    for (int i = 0; i < STRB_W; i++) begin
      if (beat.strb[i] && i < (1 << req.size))
        model[MEM_AW'(a + i)] = beat.data[8*i +: 8];
    end
  endfunction

  function automatic logic [DATA_W-1:0] expected_rdata(addr_req_t req, int k, resp_e resp);
    logic [DATA_W-1:0] data;
    logic [MEM_AW-1:0] a;
    data = '0;                          // error beats and upper lanes stay zero
    a    = beat_addr_of(req, k);
    for (int i = 0; i < STRB_W; i++) begin
      if (resp == RESP_OKAY && i < (1 << req.size))
        data[8*i +: 8] = model[MEM_AW'(a + i)];
    end
    return data;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0d ns: %s", $time, what);
    errors++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // channel monitors, sampled on the rising edge

  always @(posedge clk) begin
    if (resetn) begin
      if (aw_valid && aw_ready) begin
        if (wr_open)
          report_error("write address accepted while a write burst was still open");
        wr_req  = aw;
        wr_resp = expected_resp(aw);
        wr_beat = 0;
        wr_mark = errors;
        wr_open = 1'b1;
      end
      if (w_valid && w_ready) begin
        if (!wr_open)
          report_error("write beat accepted with no open write burst");
        else if (wr_resp == RESP_OKAY)
          write_model(wr_req, wr_beat, w);
        wr_beat++;
      end
      if (b_valid && b_ready) begin
        if (!wr_open) begin
          report_error("write response with no open write burst");
        end else begin
          if (wr_beat != wr_req.len + 1)
            report_error("write response before every write beat was taken");
          check_value("b.id", b.id, wr_req.id);
          check_value("b.resp", b.resp, wr_resp);
          writes_done++;
          $display("%0d ns write %0d id %h addr %h len %0d size %0d burst %0d resp %0d %s",
                   $time, writes_done, wr_req.id, wr_req.addr, wr_req.len, wr_req.size,
                   wr_req.burst, wr_resp, (errors == wr_mark) ? "ok" : "mismatch");
        end
        wr_open = 1'b0;
      end

      if (ar_valid && ar_ready) begin
        if (rd_open)
          report_error("read address accepted while a read burst was still open");
        rd_req  = ar;
        rd_resp = expected_resp(ar);
        rd_beat = 0;
        rd_mark = errors;
        rd_open = 1'b1;
      end
      if (r_valid && r_ready) begin
        if (!rd_open) begin
          report_error("read beat with no open read burst");
        end else begin
          check_value("r.id", r.id, rd_req.id);
          check_value("r.resp", r.resp, rd_resp);
          check_value("r.data", r.data, expected_rdata(rd_req, rd_beat, rd_resp));
          check_value("r.last", r.last, rd_beat == rd_req.len);
          rd_beat++;
          if (rd_beat == rd_req.len + 1) begin
            reads_done++;
            rd_open = 1'b0;
            $display("%0d ns read  %0d id %h addr %h len %0d size %0d burst %0d resp %0d %s",
                     $time, reads_done, rd_req.id, rd_req.addr, rd_req.len, rd_req.size,
                     rd_req.burst, rd_resp, (errors == rd_mark) ? "ok" : "mismatch");
          end
        end
      end
    end
  end

endmodule

/* verification/axi_mem_tb.sv */
`timescale 1ns/1ps

module axi_mem_tb;
  import axi_mem_pkg::*;

  localparam int CLK_PERIOD       = 20;
  localparam int N_TRANS          = 200;
  localparam int CYCLES_PER_TRANS = 80;  // a 16 beat burst with the longest gaps fits

  logic      clk = 1'b0;
  logic      resetn;
  logic      aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic      ar_valid, ar_ready, r_valid, r_ready;
  addr_req_t aw, ar;
  w_beat_t   w;
  b_resp_t   b;
  r_beat_t   r;

  int seed;
  int n_writes = 0;
  int n_reads  = 0;
  int lost     = 0;
  int errors, writes_done, reads_done;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_mem_slave uut (.*);

  axi_mem_checker u_checker (.*);

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic addr_req_t rand_req();
    addr_req_t req;
    req.id    = ID_W'(rand_below(16));
    req.len   = LEN_W'(rand_below(16));
    req.size  = 3'(rand_below(4));
    req.burst = burst_e'(2'(rand_below(3)));
    if (rand_below(8) == 0)
      req.addr = 32'(MEM_BYTES + rand_below(4096));  // past the end of memory
    else
      req.addr = 32'(rand_below(MEM_BYTES));
    return req;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // master side, one burst at a time

  task automatic run_write();
    addr_req_t req;
    w_beat_t   beat;
    int        gap;
    req = rand_req();
    n_writes++;
    repeat (rand_below(4)) @(posedge clk);
    aw_valid <= 1'b1;
    aw       <= req;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    aw_valid <= 1'b0;
    for (int k = 0; k <= req.len; k++) begin
      gap = rand_below(4);
      if (gap > 0) begin
        w_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      beat.data = $random(seed);
      beat.strb = STRB_W'(rand_below(16));
      beat.last = (k == req.len);
      w_valid <= 1'b1;
      w       <= beat;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
    end
    w_valid <= 1'b0;
    repeat (rand_below(4)) @(posedge clk);  // b stall
    b_ready <= 1'b1;
    @(posedge clk);
    while (!b_valid) @(posedge clk);
    b_ready <= 1'b0;
  endtask

  task automatic run_read();
    addr_req_t req;
    int        gap;
    req = rand_req();
    n_reads++;
    repeat (rand_below(4)) @(posedge clk);
    ar_valid <= 1'b1;
    ar       <= req;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    ar_valid <= 1'b0;
    for (int k = 0; k <= req.len; k++) begin
      gap = rand_below(4);
      if (gap > 0) begin
        r_ready <= 1'b0;               // stall with the beat pending
        repeat (gap) @(posedge clk);
      end
      r_ready <= 1'b1;
      @(posedge clk);
      while (!r_valid) @(posedge clk);
    end
    r_ready <= 1'b0;
  endtask

  initial begin
    seed     = 32'hc222808f;
    resetn   = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    for (int t = 0; t < N_TRANS; t++) begin
      if (rand_below(2) == 0)
        run_write();
      else
        run_read();
    end
    repeat (2) @(posedge clk);  // let the checker see the last edge
    if (writes_done != n_writes || reads_done != n_reads) begin
      $display("Error: issued %0d writes and %0d reads, checker closed %0d and %0d",
               n_writes, n_reads, writes_done, reads_done);
      lost++;
    end
    $display("%0d writes, %0d reads, %0d errors", writes_done, reads_done, errors + lost);
    if (errors + lost == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #(N_TRANS * CYCLES_PER_TRANS * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d ns",
             N_TRANS * CYCLES_PER_TRANS * CLK_PERIOD);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
